// ==== design/cache_geom_pkg.sv ====
//##########################################################
// cache geometry
// address split, line size and way count
// scalar types shared by the datapath and the controller
//##########################################################

package cache_geom_pkg;

    localparam int ADDR_BITS      = 25;  // processor word address
    localparam int WORD_SEL_BITS  = 2;
    localparam int WORDS_PER_LINE = 4;
    localparam int NUM_WAYS       = 8;
    localparam int WAY_BITS       = 3;
    localparam int PLRU_BITS      = 7;   // one bit per inner tree node
    localparam int LINE_ADDR_BITS = ADDR_BITS - WORD_SEL_BITS;

    typedef logic [31:0] word_t;

    // word 0 sits in the low bits
    typedef word_t [WORDS_PER_LINE-1:0] line_t;

    typedef logic [3:0] byte_en_t;
    typedef logic [NUM_WAYS-1:0] way_mask_t;
    typedef logic [WAY_BITS-1:0] way_idx_t;
    typedef logic [PLRU_BITS-1:0] plru_t;
    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;

endpackage

// ==== design/cache_bus_pkg.sv ====
//##########################################################
// bundles crossing the cache boundary
// processor request and response
// memory request and response
// status reported by each way to the controller
//##########################################################

package cache_bus_pkg;

    typedef struct packed {
        logic [cache_geom_pkg::ADDR_BITS-1:0] addr;
        cache_geom_pkg::byte_en_t             byte_en;
        cache_geom_pkg::word_t                wdata;
        logic                                 read;
        logic                                 write;
    } cpu_req_t;

    typedef struct packed {
        cache_geom_pkg::word_t rdata;
        logic                  rdata_valid;  // one-cycle pulse
        logic                  waitrequest;
    } cpu_rsp_t;

    typedef struct packed {
        cache_geom_pkg::line_addr_t addr;
        cache_geom_pkg::line_t      wdata;
        logic                       read;
        logic                       write;
    } mem_req_t;

    typedef struct packed {
        cache_geom_pkg::line_t rdata;
        logic                  rdata_valid;
        logic                  waitrequest;
    } mem_rsp_t;

    typedef struct packed {
        logic                       hit;
        logic                       valid;
        logic                       dirty;
        cache_geom_pkg::line_addr_t line_addr;  // where the stored line lives in memory
    } way_stat_t;

endpackage

// ==== design/sync_ram.sv ====
//##########################################################
// simple dual-port RAM, one read and one write port
// registered read, payload given by a type parameter
//##########################################################

module sync_ram #(
    parameter type payload_t  = logic [7:0],
    parameter int  DEPTH_BITS = 9
) (
    input  logic                  clk,
    input  logic                  i_wr_en,
    input  logic [DEPTH_BITS-1:0] i_wr_addr,
    input  payload_t              i_wr_data,
    input  logic [DEPTH_BITS-1:0] i_rd_addr,
    output payload_t              o_rd_data
);

    payload_t mem [2**DEPTH_BITS];

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
        if (i_wr_en && (i_wr_addr == i_rd_addr)) begin
            o_rd_data <= i_wr_data;  // new data wins on a collision
        end else begin
            o_rd_data <= mem[i_rd_addr];
        end
    end

endmodule

// ==== design/cache_way.sv ====
//##########################################################
// one cache way
// line data RAM and tag RAM holding {dirty, valid, tag}
// byte lane merge for partial writes
// hit test against the registered request tag
//##########################################################

module cache_way #(
    parameter  int SET_BITS = 9,
    localparam int TAG_BITS = cache_geom_pkg::LINE_ADDR_BITS - SET_BITS
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic [SET_BITS-1:0]                       i_index,
    input  logic [TAG_BITS-1:0]                       i_tag,
    input  cache_geom_pkg::line_t                     i_wdata,
    input  logic [cache_geom_pkg::WORDS_PER_LINE-1:0] i_word_en,
    input  cache_geom_pkg::byte_en_t                  i_byte_en,
    input  logic                                      i_write,
    input  logic                                      i_fill,
    output cache_geom_pkg::line_t                     o_rdata,
    output cache_bus_pkg::way_stat_t                  o_stat
);

    typedef struct packed {
        logic                dirty;
        logic                valid;
        logic [TAG_BITS-1:0] tag;
    } tag_entry_t;

    tag_entry_t            tag_wr;
    tag_entry_t            tag_rd;
    cache_geom_pkg::line_t line_wr;
    logic [SET_BITS-1:0]   index_q;
    logic [TAG_BITS-1:0]   tag_q;

    // lanes outside the word and byte masks keep the stored line
    always_comb begin
        line_wr = o_rdata;
        for (int w = 0; w < cache_geom_pkg::WORDS_PER_LINE; w++) begin
            for (int b = 0; b < 4; b++) begin
                if (i_word_en[w] && i_byte_en[b]) begin
                    line_wr[w][8*b +: 8] = i_wdata[w][8*b +: 8];
                end
            end
        end
    end

    // a write with no word selected clears the entry
    assign tag_wr = '{dirty: !i_fill, valid: |i_word_en, tag: i_tag};

    sync_ram #(
        .payload_t  (cache_geom_pkg::line_t),
        .DEPTH_BITS (SET_BITS)
    ) data_ram (
        .clk       (clk),
        .i_wr_en   (i_write),
        .i_wr_addr (i_index),
        .i_wr_data (line_wr),
        .i_rd_addr (i_index),
        .o_rd_data (o_rdata)
    );

    sync_ram #(
        .payload_t  (tag_entry_t),
        .DEPTH_BITS (SET_BITS)
    ) tag_ram (
        .clk       (clk),
        .i_wr_en   (i_write),
        .i_wr_addr (i_index),
        .i_wr_data (tag_wr),
        .i_rd_addr (i_index),
        .o_rd_data (tag_rd)
    );

    always_ff @(posedge clk) begin
        index_q <= i_index;
        tag_q   <= i_tag;
    end

    assign o_stat.hit       = tag_rd.valid && (tag_rd.tag == tag_q);
    assign o_stat.valid     = tag_rd.valid;
    assign o_stat.dirty     = tag_rd.dirty;
    assign o_stat.line_addr = {tag_rd.tag, index_q};

    // the controller never writes a way with every byte lane off
    assert property (@(posedge clk) disable iff (rst) i_write |-> |i_byte_en)
        else $error("way write with no byte enabled");

endmodule

// ==== design/plru_tree.sv ====
//##########################################################
// tree pseudo-LRU for eight ways
// per-set state RAM, victim walk and update on access
// zero state written during the reset sweep
//##########################################################

module plru_tree #(
    parameter int SET_BITS = 9
) (
    input  logic                     clk,
    input  logic [SET_BITS-1:0]      i_index,
    input  logic                     i_update,
    input  cache_geom_pkg::way_idx_t i_way,
    input  logic                     i_clear,
    output cache_geom_pkg::way_idx_t o_victim
);

    cache_geom_pkg::plru_t state_rd;
    cache_geom_pkg::plru_t state_next;
    cache_geom_pkg::plru_t wr_data;
    cache_geom_pkg::way_idx_t victim;
    logic [SET_BITS-1:0]   index_q;
    logic [SET_BITS-1:0]   wr_addr;

    // node n has children 2n+1 and 2n+2
    // a set bit sends the victim to the upper child
    always_comb begin
        victim[2] = state_rd[0];
        victim[1] = state_rd[1 + victim[2]];
        victim[0] = state_rd[3 + victim[2:1]];
    end

    assign o_victim = victim;

    // every node on the accessed path points away from it
    always_comb begin
        state_next                 = state_rd;
        state_next[0]              = ~i_way[2];
        state_next[1 + i_way[2]]   = ~i_way[1];
        state_next[3 + i_way[2:1]] = ~i_way[0];
    end

    always_ff @(posedge clk) begin
        index_q <= i_index;
    end

    assign wr_addr = i_clear ? i_index : index_q;
    assign wr_data = i_clear ? '0 : state_next;

    sync_ram #(
        .payload_t  (cache_geom_pkg::plru_t),
        .DEPTH_BITS (SET_BITS)
    ) state_ram (
        .clk       (clk),
        .i_wr_en   (i_update || i_clear),
        .i_wr_addr (wr_addr),
        .i_wr_data (wr_data),
        .i_rd_addr (i_index),
        .o_rd_data (state_rd)
    );

endmodule

// ==== design/cache_ctrl.sv ====
//##########################################################
// cache controller
// access FSM, way choice, line fill and dirty write-back
// reset sweep over every set
//##########################################################

module cache_ctrl #(
    parameter  int SET_BITS = 9,
    localparam int TAG_BITS = cache_geom_pkg::LINE_ADDR_BITS - SET_BITS
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  cache_bus_pkg::cpu_req_t                   i_cpu,
    output cache_bus_pkg::cpu_rsp_t                   o_cpu,
    output cache_bus_pkg::mem_req_t                   o_mem,
    input  cache_bus_pkg::mem_rsp_t                   i_mem,
    output logic [SET_BITS-1:0]                       o_index,
    output logic [TAG_BITS-1:0]                       o_tag,
    output cache_geom_pkg::line_t                     o_wdata,
    output logic [cache_geom_pkg::WORDS_PER_LINE-1:0] o_word_en,
    output cache_geom_pkg::byte_en_t                  o_byte_en,
    output cache_geom_pkg::way_mask_t                 o_way_write,
    output logic                                      o_fill,
    input  cache_geom_pkg::line_t                     i_way_rdata [cache_geom_pkg::NUM_WAYS],
    input  cache_bus_pkg::way_stat_t                  i_way_stat [cache_geom_pkg::NUM_WAYS],
    output logic                                      o_plru_update,
    output cache_geom_pkg::way_idx_t                  o_plru_way,
    output logic                                      o_plru_clear,
    input  cache_geom_pkg::way_idx_t                  i_victim
);

    typedef enum logic [3:0] {
        ST_SWEEP,
        ST_IDLE,
        ST_COMPARE,
        ST_HIT_WRITE,
        ST_FETCH_REQ,
        ST_FETCH_WAIT,
        ST_FETCH_WRITE,
        ST_WB_LOAD,
        ST_WB_REQ
    } state_t;

    state_t                                  state;
    cache_bus_pkg::cpu_req_t                 req_q;
    cache_bus_pkg::mem_req_t                 mem_q;
    cache_geom_pkg::word_t                   rdata_q;
    logic                                    rvalid_q;
    logic [SET_BITS-1:0]                     sweep_cnt;
    cache_geom_pkg::way_idx_t                way_q;
    cache_geom_pkg::way_mask_t               way_mask;
    cache_geom_pkg::way_mask_t               hit_mask;
    cache_geom_pkg::way_mask_t               valid_mask;
    cache_geom_pkg::way_idx_t                hit_idx;
    cache_geom_pkg::way_idx_t                inv_idx;
    cache_geom_pkg::way_idx_t                acc_idx;
    logic [cache_geom_pkg::ADDR_BITS-1:0]    addr_sel;
    logic [cache_geom_pkg::WORD_SEL_BITS-1:0] word_sel;
    cache_geom_pkg::line_addr_t              line_addr;
    logic                                    idle;

    // lowest way wins in both searches
    always_comb begin
        hit_idx = '0;
        inv_idx = '0;
        for (int w = cache_geom_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            hit_mask[w]   = i_way_stat[w].hit;
            valid_mask[w] = i_way_stat[w].valid;
            if (i_way_stat[w].hit) begin
                hit_idx = cache_geom_pkg::way_idx_t'(w);
            end
            if (!i_way_stat[w].valid) begin
                inv_idx = cache_geom_pkg::way_idx_t'(w);
            end
        end
        if (|hit_mask) begin
            acc_idx = hit_idx;
        end else if (!(&valid_mask)) begin
            acc_idx = inv_idx;
        end else begin
            acc_idx = i_victim;
        end
    end

    assign idle      = (state == ST_IDLE);
    assign addr_sel  = idle ? i_cpu.addr : req_q.addr;  // tags and data ready by compare
    assign word_sel  = req_q.addr[cache_geom_pkg::WORD_SEL_BITS-1:0];
    assign line_addr = req_q.addr[cache_geom_pkg::ADDR_BITS-1:cache_geom_pkg::WORD_SEL_BITS];
    assign way_mask  = cache_geom_pkg::way_mask_t'(1) << way_q;

    assign o_index = (state == ST_SWEEP) ? sweep_cnt
                                         : addr_sel[cache_geom_pkg::WORD_SEL_BITS +: SET_BITS];
    assign o_tag   = addr_sel[cache_geom_pkg::ADDR_BITS-1 -: TAG_BITS];
    assign o_wdata = (state == ST_FETCH_WAIT) ? i_mem.rdata
                                              : {cache_geom_pkg::WORDS_PER_LINE{req_q.wdata}};
    assign o_fill  = (state == ST_SWEEP) || (state == ST_FETCH_WAIT);

    always_comb begin
        o_word_en           = '0;
        o_word_en[word_sel] = 1'b1;
        o_byte_en           = req_q.byte_en;
        o_way_write         = '0;
        case (state)
            ST_SWEEP: begin
                o_word_en   = '0;
                o_byte_en   = '1;
                o_way_write = '1;
            end
            ST_FETCH_WAIT: begin
                o_word_en   = '1;
                o_byte_en   = '1;
                o_way_write = i_mem.rdata_valid ? way_mask : '0;
            end
            ST_HIT_WRITE, ST_FETCH_WRITE: begin
                o_way_write = (|req_q.byte_en) ? way_mask : '0;
            end
            default: begin
            end
        endcase
    end

    assign o_plru_update = (state == ST_COMPARE);
    assign o_plru_way    = acc_idx;
    assign o_plru_clear  = (state == ST_SWEEP);

    assign o_cpu.rdata       = rdata_q;
    assign o_cpu.rdata_valid = rvalid_q;
    assign o_cpu.waitrequest = !idle;
    assign o_mem             = mem_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_SWEEP;
            sweep_cnt   <= '0;
            rvalid_q    <= 1'b0;
            mem_q.read  <= 1'b0;
            mem_q.write <= 1'b0;
        end else begin
            rvalid_q <= 1'b0;
            case (state)
                ST_SWEEP: begin
                    sweep_cnt <= sweep_cnt + 1'b1;
                    if (&sweep_cnt) begin
                        state <= ST_IDLE;
                    end
                end
                ST_IDLE: begin
                    if (i_cpu.read || i_cpu.write) begin
                        req_q <= i_cpu;  // read wins when both are set
                        state <= ST_COMPARE;
                    end
                end
                ST_COMPARE: begin
                    way_q <= acc_idx;
                    if (|hit_mask) begin
                        if (req_q.read) begin
                            rdata_q  <= i_way_rdata[hit_idx][word_sel];
                            rvalid_q <= 1'b1;
                            state    <= ST_IDLE;
                        end else begin
                            state <= ST_HIT_WRITE;
                        end
                    end else if (i_way_stat[acc_idx].valid && i_way_stat[acc_idx].dirty) begin
                        state <= ST_WB_LOAD;
                    end else begin
                        mem_q.addr <= line_addr;
                        mem_q.read <= 1'b1;
                        state      <= ST_FETCH_REQ;
                    end
                end
                ST_HIT_WRITE, ST_FETCH_WRITE: begin
                    state <= ST_IDLE;
                end
                ST_FETCH_REQ: begin
                    if (!i_mem.waitrequest) begin
                        mem_q.read <= 1'b0;
                        state      <= ST_FETCH_WAIT;
                    end
                end
                ST_FETCH_WAIT: begin
                    if (i_mem.rdata_valid) begin
                        if (req_q.read) begin
                            rdata_q  <= i_mem.rdata[word_sel];
                            rvalid_q <= 1'b1;
                            state    <= ST_IDLE;
                        end else begin
                            state <= ST_FETCH_WRITE;  // word goes into the fresh line
                        end
                    end
                end
                ST_WB_LOAD: begin
                    mem_q.addr  <= i_way_stat[way_q].line_addr;
                    mem_q.wdata <= i_way_rdata[way_q];
                    mem_q.write <= 1'b1;
                    state       <= ST_WB_REQ;
                end
                ST_WB_REQ: begin
                    if (!i_mem.waitrequest) begin
                        mem_q.write <= 1'b0;
                        mem_q.addr  <= line_addr;
                        mem_q.read  <= 1'b1;
                        state       <= ST_FETCH_REQ;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // a tag lives in at most one way of a set
    assert property (@(posedge clk) disable iff (rst)
        (state == ST_COMPARE) |-> $onehot0(hit_mask))
        else $error("more than one way hit");

    assert property (@(posedge clk) disable iff (rst) !(o_mem.read && o_mem.write))
        else $error("memory read and write strobes together");

    // memory only answers the single outstanding fetch
    assert property (@(posedge clk) disable iff (rst)
        i_mem.rdata_valid |-> (state == ST_FETCH_WAIT))
        else $error("memory read data outside a fetch");

endmodule

// ==== design/cache_top.sv ====
//##########################################################
// 8-way write-back cache top level
// controller, eight ways and the pseudo-LRU tree
//##########################################################

module cache_top #(
    parameter int SET_BITS = 9
) (
    input  logic                    clk,
    input  logic                    rst,
    input  cache_bus_pkg::cpu_req_t i_cpu,
    output cache_bus_pkg::cpu_rsp_t o_cpu,
    output cache_bus_pkg::mem_req_t o_mem,
    input  cache_bus_pkg::mem_rsp_t i_mem
);

    localparam int TAG_BITS = cache_geom_pkg::LINE_ADDR_BITS - SET_BITS;

    logic [SET_BITS-1:0]                       index;
    logic [TAG_BITS-1:0]                       tag;
    cache_geom_pkg::line_t                     wdata;
    logic [cache_geom_pkg::WORDS_PER_LINE-1:0] word_en;
    cache_geom_pkg::byte_en_t                  byte_en;
    cache_geom_pkg::way_mask_t                 way_write;
    logic                                      fill;
    cache_geom_pkg::line_t                     way_rdata [cache_geom_pkg::NUM_WAYS];
    cache_bus_pkg::way_stat_t                  way_stat [cache_geom_pkg::NUM_WAYS];
    logic                                      plru_update;
    logic                                      plru_clear;
    cache_geom_pkg::way_idx_t                  plru_way;
    cache_geom_pkg::way_idx_t                  victim;

    cache_ctrl #(.SET_BITS(SET_BITS)) ctrl_inst (
        .clk           (clk),
        .rst           (rst),
        .i_cpu         (i_cpu),
        .o_cpu         (o_cpu),
        .o_mem         (o_mem),
        .i_mem         (i_mem),
        .o_index       (index),
        .o_tag         (tag),
        .o_wdata       (wdata),
        .o_word_en     (word_en),
        .o_byte_en     (byte_en),
        .o_way_write   (way_write),
        .o_fill        (fill),
        .i_way_rdata   (way_rdata),
        .i_way_stat    (way_stat),
        .o_plru_update (plru_update),
        .o_plru_way    (plru_way),
        .o_plru_clear  (plru_clear),
        .i_victim      (victim)
    );

    for (genvar g = 0; g < cache_geom_pkg::NUM_WAYS; g++) begin : g_way
        cache_way #(.SET_BITS(SET_BITS)) way_inst (
            .clk       (clk),
            .rst       (rst),
            .i_index   (index),
            .i_tag     (tag),
            .i_wdata   (wdata),
            .i_word_en (word_en),
            .i_byte_en (byte_en),
            .i_write   (way_write[g]),
            .i_fill    (fill),
            .o_rdata   (way_rdata[g]),
            .o_stat    (way_stat[g])
        );
    end

    plru_tree #(.SET_BITS(SET_BITS)) plru_inst (
        .clk      (clk),
        .i_index  (index),
        .i_update (plru_update),
        .i_way    (plru_way),
        .i_clear  (plru_clear),
        .o_victim (victim)
    );

endmodule

// ==== sim/tb_clk_gen.sv ====
//##########################################################
// testbench clock and reset source
// free running clock, reset held for a few cycles
//##########################################################

module tb_clk_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD / 2) o_clk = ~o_clk;
        end
    end

    // release away from the stimulus point after the edge
    initial begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #(PERIOD / 4) o_rst = 1'b0;
    end

endmodule

// ==== sim/tb_cache.sv ====
//##########################################################
// testbench for the 8-way write-back cache
// random processor traffic over a small address pool
// memory responder with random stalls and return delays
// flat word model, read data and write-back line checks
// hit latency and pseudo-LRU retention checks
//##########################################################

module tb_cache;

    localparam int SET_BITS     = 9;
    localparam int TAG_BITS     = cache_geom_pkg::LINE_ADDR_BITS - SET_BITS;
    localparam int SWEEP_CYCLES = 2 ** SET_BITS;
    localparam int NUM_REQS     = 1500;
    localparam int POOL_SETS    = 3;
    localparam int POOL_TAGS    = 12;
    localparam int PLRU_TAGS    = 9;
    // repeat reads add about one request in eight
    localparam int MAX_CYCLES   = (NUM_REQS + NUM_REQS / 4 + PLRU_TAGS + 3) * 40 + SWEEP_CYCLES;

    typedef logic [cache_geom_pkg::ADDR_BITS-1:0] word_addr_t;

    logic                       clk;
    logic                       rst;
    cache_bus_pkg::cpu_req_t    cpu_req;
    cache_bus_pkg::cpu_rsp_t    cpu_rsp;
    cache_bus_pkg::mem_req_t    mem_req;
    cache_bus_pkg::mem_rsp_t    mem_rsp;

    integer                     seed;
    int                         cycle_count;
    int                         word_errors;
    int                         line_errors;
    int                         protocol_errors;
    int                         mem_reads;
    int                         mem_writes;
    logic                       fetch_pending;
    int                         fetch_delay;
    cache_geom_pkg::line_addr_t fetch_addr;

    cache_geom_pkg::word_t      model_mem [int];  // processor view, by word address
    cache_geom_pkg::line_t      mem_store [int];  // backing memory, by line address

    tb_clk_gen #(.PERIOD(40), .RESET_CYCLES(2)) clk_gen_inst (
        .o_clk (clk),
        .o_rst (rst)
    );

    cache_top #(.SET_BITS(SET_BITS)) cache_top_inst (
        .clk   (clk),
        .rst   (rst),
        .i_cpu (cpu_req),
        .o_cpu (cpu_rsp),
        .o_mem (mem_req),
        .i_mem (mem_rsp)
    );

    // odd multiplier keeps every address bit in the pattern
    function automatic cache_geom_pkg::word_t init_word(input word_addr_t addr);
        return (32'(addr) * 32'h9e3779b1) ^ 32'h3c5a0000;
    endfunction

    function automatic cache_geom_pkg::word_t model_word(input word_addr_t addr);
        if (model_mem.exists(int'(addr))) begin
            return model_mem[int'(addr)];
        end
        return init_word(addr);
    endfunction

    function automatic cache_geom_pkg::line_t model_line(input cache_geom_pkg::line_addr_t la);
        cache_geom_pkg::line_t line;
        for (int w = 0; w < cache_geom_pkg::WORDS_PER_LINE; w++) begin
            line[w] = model_word({la, 2'(w)});
        end
        return line;
    endfunction

    function automatic cache_geom_pkg::line_t stored_line(input cache_geom_pkg::line_addr_t la);
        cache_geom_pkg::line_t line;
        if (mem_store.exists(int'(la))) begin
            return mem_store[int'(la)];
        end
        for (int w = 0; w < cache_geom_pkg::WORDS_PER_LINE; w++) begin
            line[w] = init_word({la, 2'(w)});
        end
        return line;
    endfunction

    function automatic word_addr_t pool_addr(input int set_slot, input int tag_slot,
                                             input logic [1:0] word);
        logic [SET_BITS-1:0] set_idx;
        logic [TAG_BITS-1:0] tag;
        case (set_slot)
            0:       set_idx = SET_BITS'('h013);
            1:       set_idx = SET_BITS'('h0a7);
            2:       set_idx = SET_BITS'('h1f2);
            default: set_idx = SET_BITS'('h0c4);  // kept apart for the pLRU test
        endcase
        tag = TAG_BITS'(tag_slot * 37 + 5);
        return {tag, set_idx, word};
    endfunction

    task automatic model_write(input word_addr_t addr, input cache_geom_pkg::byte_en_t be,
                               input cache_geom_pkg::word_t wdata);
        cache_geom_pkg::word_t merged;
        merged = model_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                merged[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        model_mem[int'(addr)] = merged;
    endtask

    task automatic check_word(input string name, input cache_geom_pkg::word_t got,
                              input cache_geom_pkg::word_t exp);
        if (got !== exp) begin
            word_errors++;
            $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input cache_geom_pkg::line_t got,
                              input cache_geom_pkg::line_t exp);
        if (got !== exp) begin
            line_errors++;
            $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic flag_protocol(input string what);
        protocol_errors++;
        $display("t=%0t %s", $time, what);
    endtask

    // one memory cycle, run right after the stimulus point
    task automatic respond_mem();
        logic [31:0] rnd;
        mem_rsp.rdata_valid = 1'b0;
        mem_rsp.rdata       = '0;
        if (fetch_pending) begin
            if (fetch_delay == 0) begin
                mem_rsp.rdata       = stored_line(fetch_addr);
                mem_rsp.rdata_valid = 1'b1;
                fetch_pending       = 1'b0;
            end else begin
                fetch_delay--;
            end
        end
        rnd = $random(seed);
        mem_rsp.waitrequest = (rnd[1:0] == 2'b00);
        if (!mem_rsp.waitrequest && mem_req.read) begin
            fetch_pending = 1'b1;
            fetch_addr    = mem_req.addr;
            fetch_delay   = int'(rnd[3:2]);
            mem_reads++;
        end
        if (!mem_rsp.waitrequest && mem_req.write) begin
            check_line($sformatf("mem wdata[%h]", mem_req.addr), mem_req.wdata,
                       model_line(mem_req.addr));
            mem_store[int'(mem_req.addr)] = mem_req.wdata;
            mem_writes++;
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #5;
        respond_mem();
    endtask

    task automatic cpu_access(input logic is_read, input word_addr_t addr,
                              input cache_geom_pkg::byte_en_t be,
                              input cache_geom_pkg::word_t wdata, output int latency);
        cache_geom_pkg::word_t expected;
        while (cpu_rsp.waitrequest) begin
            tick();
        end
        cpu_req.addr    = addr;
        cpu_req.byte_en = be;
        cpu_req.wdata   = wdata;
        cpu_req.read    = is_read;
        cpu_req.write   = !is_read;
        tick();
        cpu_req.read  = 1'b0;  // taken at the edge just passed
        cpu_req.write = 1'b0;
        latency       = 1;
        if (is_read) begin
            expected = model_word(addr);
            while (!cpu_rsp.rdata_valid) begin
                tick();
                latency++;
            end
            check_word($sformatf("rdata[%h]", addr), cpu_rsp.rdata, expected);
        end else begin
            model_write(addr, be, wdata);
            while (cpu_rsp.waitrequest) begin
                tick();
                latency++;
            end
        end
    endtask

    task automatic expect_hit(input string what, input int latency, input int reads_before);
        if (mem_reads != reads_before) begin
            flag_protocol($sformatf("%s went to memory instead of hitting", what));
        end
        if (latency != 2) begin
            flag_protocol($sformatf("%s returned data %0d cycles after acceptance, not 2",
                                    what, latency));
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("errors: word %0d, line %0d, protocol %0d",
                     word_errors, line_errors, protocol_errors);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        int                    sweep_len;
        int                    latency;
        int                    reads_before;
        logic [31:0]           rnd;
        cache_geom_pkg::word_t wdata;
        word_addr_t            addr;

        seed            = 32'h35842b0e;
        cycle_count     = 0;
        word_errors     = 0;
        line_errors     = 0;
        protocol_errors = 0;
        mem_reads       = 0;
        mem_writes      = 0;
        fetch_pending   = 1'b0;
        fetch_delay     = 0;
        fetch_addr      = '0;
        cpu_req         = '0;
        mem_rsp         = '0;

        // reset sweep, no traffic on either port
        @(negedge rst);
        sweep_len = 0;
        tick();
        while (cpu_rsp.waitrequest && sweep_len <= SWEEP_CYCLES + 4) begin
            if (mem_req.read || mem_req.write || cpu_rsp.rdata_valid) begin
                flag_protocol("memory strobe or read valid seen during the reset sweep");
            end
            sweep_len++;
            tick();
        end
        if (cpu_rsp.waitrequest || sweep_len < SWEEP_CYCLES - 2) begin
            flag_protocol($sformatf("waitrequest fell after %0d cycles, expected about %0d",
                                    sweep_len, SWEEP_CYCLES));
        end

        for (int n = 0; n < NUM_REQS; n++) begin
            rnd   = $random(seed);
            wdata = $random(seed);
            addr  = pool_addr(int'(rnd[7:0]) % POOL_SETS, int'(rnd[15:8]) % POOL_TAGS,
                              rnd[17:16]);
            cpu_access(rnd[18], addr, rnd[22:19], wdata, latency);
            if (rnd[25:23] == 3'd0) begin
                reads_before = mem_reads;
                cpu_access(1'b1, addr, '0, '0, latency);
                expect_hit("repeat read", latency, reads_before);
            end
        end

        // eight tags fill a fresh set, tag 0 is read again before the ninth
        for (int k = 0; k < PLRU_TAGS - 1; k++) begin
            cpu_access(1'b1, pool_addr(POOL_SETS, k, 2'd1), '0, '0, latency);
        end
        reads_before = mem_reads;
        cpu_access(1'b1, pool_addr(POOL_SETS, 0, 2'd1), '0, '0, latency);
        expect_hit("first line of a full set", latency, reads_before);
        cpu_access(1'b1, pool_addr(POOL_SETS, PLRU_TAGS - 1, 2'd1), '0, '0, latency);

        // the ninth tag and tag 0 are the two most recent and must survive
        reads_before = mem_reads;
        cpu_access(1'b1, pool_addr(POOL_SETS, PLRU_TAGS - 1, 2'd1), '0, '0, latency);
        expect_hit("most recently filled line", latency, reads_before);
        reads_before = mem_reads;
        cpu_access(1'b1, pool_addr(POOL_SETS, 0, 2'd1), '0, '0, latency);
        expect_hit("recently read line in a full set", latency, reads_before);

        if (mem_writes == 0) begin
            flag_protocol("no dirty line was ever written back to memory");
        end

        $display("errors: word %0d, line %0d, protocol %0d",
                 word_errors, line_errors, protocol_errors);
        if (word_errors + line_errors + protocol_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
design/cache_geom_pkg.sv
design/cache_bus_pkg.sv
design/sync_ram.sv
design/cache_way.sv
design/plru_tree.sv
design/cache_ctrl.sv
design/cache_top.sv
sim/tb_clk_gen.sv
sim/tb_cache.sv

// ==== Bender.yml ====
package:
  name: assoc_cache

sources:
  - design/cache_geom_pkg.sv
  - design/cache_bus_pkg.sv
  - design/sync_ram.sv
  - design/cache_way.sv
  - design/plru_tree.sv
  - design/cache_ctrl.sv
  - design/cache_top.sv
  - target: test
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_cache.sv
